/* design/cpu_pkg.sv */
package cpu_pkg;

    // datapath widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h0;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h1;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h5;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h6;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h30;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h31;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h32;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h33;

    // field positions
    localparam int crmd_plv_hi       = 1;
    localparam int crmd_plv_lo       = 0;
    localparam int crmd_ie           = 2;
    localparam int prmd_pplv_hi      = 1;
    localparam int prmd_pplv_lo      = 0;
    localparam int prmd_pie          = 2;
    localparam int estat_ecode_hi    = 21;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_esubcode_hi = 30;
    localparam int estat_esubcode_lo = 22;

    // exception codes
    localparam logic [ecode_w-1:0] ecode_sys = 6'hb;

    // writable bits per csr
    localparam logic [data_w-1:0] crmd_wmask   = 32'h0000_0007;
    localparam logic [data_w-1:0] prmd_wmask   = 32'h0000_0007;
    localparam logic [data_w-1:0] estat_wmask  = 32'h0000_0003;
    localparam logic [data_w-1:0] eentry_wmask = 32'hffff_ffc0;

endpackage

/* design/csr_file.sv */
module csr_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // software access
    input  logic [csr_num_w-1:0]  csr_num,
    input  logic                  csr_we,
    input  logic [data_w-1:0]     csr_wmask,
    input  logic [data_w-1:0]     csr_wvalue,
    // exception entry and return
    input  logic                  wb_ex,
    input  logic [data_w-1:0]     wb_pc,
    input  logic [ecode_w-1:0]    wb_ecode,
    input  logic [esubcode_w-1:0] wb_esubcode,
    input  logic                  ertn_flush,
    output logic [data_w-1:0]     csr_rvalue,
    output logic [data_w-1:0]     flush_target
);

    logic [data_w-1:0] crmd;
    logic [data_w-1:0] prmd;
    logic [data_w-1:0] estat;
    logic [data_w-1:0] era;
    logic [data_w-1:0] eentry;
    logic [data_w-1:0] save0;
    logic [data_w-1:0] save1;
    logic [data_w-1:0] save2;
    logic [data_w-1:0] save3;

    // replace only bits enabled by both masks
    function automatic logic [data_w-1:0] merge(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] reg_mask
    );
        logic [data_w-1:0] m;
        m = csr_wmask & reg_mask;
        return (old_val & ~m) | (csr_wvalue & m);
    endfunction

    // crmd and prmd, exception and ertn first
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd <= '0;
            prmd <= '0;
        end else if (wb_ex) begin
            prmd[prmd_pplv_hi:prmd_pplv_lo] <= crmd[crmd_plv_hi:crmd_plv_lo];
            prmd[prmd_pie]                  <= crmd[crmd_ie];
            crmd[crmd_plv_hi:crmd_plv_lo]   <= 2'b00;
            crmd[crmd_ie]                   <= 1'b0;
        end else if (ertn_flush) begin
            crmd[crmd_plv_hi:crmd_plv_lo] <= prmd[prmd_pplv_hi:prmd_pplv_lo];
            crmd[crmd_ie]                 <= prmd[prmd_pie];
        end else if (csr_we) begin
            if (csr_num == csr_crmd) begin
                crmd <= merge(crmd, crmd_wmask);
            end
            if (csr_num == csr_prmd) begin
                prmd <= merge(prmd, prmd_wmask);
            end
        end
    end

    // estat and era capture the faulting instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat <= '0;
            era   <= '0;
        end else if (wb_ex) begin
            estat[estat_ecode_hi:estat_ecode_lo]       <= wb_ecode;
            estat[estat_esubcode_hi:estat_esubcode_lo] <= wb_esubcode;
            era                                        <= wb_pc;
        end else if (csr_we && !ertn_flush) begin
            if (csr_num == csr_estat) begin
                estat <= merge(estat, estat_wmask);
            end
            if (csr_num == csr_era) begin
                era <= merge(era, '1);
            end
        end
    end

    // plain software registers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry <= '0;
            save0  <= '0;
            save1  <= '0;
            save2  <= '0;
            save3  <= '0;
        end else if (csr_we) begin
            case (csr_num)
                csr_eentry: eentry <= merge(eentry, eentry_wmask);
                csr_save0:  save0  <= merge(save0, '1);
                csr_save1:  save1  <= merge(save1, '1);
                csr_save2:  save2  <= merge(save2, '1);
                csr_save3:  save3  <= merge(save3, '1);
                default: ;
            endcase
        end
    end

    // read mux, unknown numbers give zero
    always_comb begin
        case (csr_num)
            csr_crmd:   csr_rvalue = crmd;
            csr_prmd:   csr_rvalue = prmd;
            csr_estat:  csr_rvalue = estat;
            csr_era:    csr_rvalue = era;
            csr_eentry: csr_rvalue = eentry;
            csr_save0:  csr_rvalue = save0;
            csr_save1:  csr_rvalue = save1;
            csr_save2:  csr_rvalue = save2;
            csr_save3:  csr_rvalue = save3;
            default:    csr_rvalue = '0;
        endcase
    end

    assign flush_target = wb_ex ? eentry : era;

endmodule

/* design/mem_stage.sv */
module mem_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // upstream source
    input  logic                  in_valid,
    input  logic [data_w-1:0]     in_pc,
    input  logic                  in_rf_we,
    input  logic [reg_addr_w-1:0] in_rf_waddr,
    input  logic [data_w-1:0]     in_rf_wdata,
    input  logic                  in_csr_re,
    input  logic                  in_csr_we,
    input  logic [csr_num_w-1:0]  in_csr_num,
    input  logic [data_w-1:0]     in_csr_wmask,
    input  logic [data_w-1:0]     in_csr_wvalue,
    input  logic                  in_syscall,
    input  logic                  in_ertn,
    output logic                  in_allowin,
    // writeback side
    input  logic                  ws_allowin,
    input  logic                  flush,
    output logic                  ms2ws_valid,
    output logic [data_w-1:0]     ms_pc,
    output logic                  ms_rf_we,
    output logic [reg_addr_w-1:0] ms_rf_waddr,
    output logic [data_w-1:0]     ms_rf_wdata,
    output logic                  ms_csr_re,
    output logic                  ms_csr_we,
    output logic [csr_num_w-1:0]  ms_csr_num,
    output logic [data_w-1:0]     ms_csr_wmask,
    output logic [data_w-1:0]     ms_csr_wvalue,
    output logic                  ms_syscall,
    output logic                  ms_ertn
);

    logic ms_valid;
    logic ms_ready_go;
    logic ms_allowin;
    logic ms_load;

    // no memory access in this stage, result is always ready
    assign ms_ready_go = 1'b1;
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws_allowin);
    assign in_allowin  = ms_allowin;
    assign ms2ws_valid = ms_valid && ms_ready_go;
    assign ms_load     = in_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (flush) begin
            // younger item behind a flushing one is dropped
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= in_valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (ms_load) begin
            ms_pc         <= in_pc;
            ms_rf_we      <= in_rf_we;
            ms_rf_waddr   <= in_rf_waddr;
            ms_rf_wdata   <= in_rf_wdata;
            ms_csr_re     <= in_csr_re;
            ms_csr_we     <= in_csr_we;
            ms_csr_num    <= in_csr_num;
            ms_csr_wmask  <= in_csr_wmask;
            ms_csr_wvalue <= in_csr_wvalue;
            ms_syscall    <= in_syscall;
            ms_ertn       <= in_ertn;
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    // write port
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [data_w-1:0]     wdata,
    // test read port
    input  logic [reg_addr_w-1:0] raddr,
    output logic [data_w-1:0]     rdata
);

    logic [data_w-1:0] regs [0:(1<<reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

/* design/wb_csr_top.sv */
module wb_csr_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // instruction results from the source
    input  logic                  in_valid,
    input  logic [data_w-1:0]     in_pc,
    input  logic                  in_rf_we,
    input  logic [reg_addr_w-1:0] in_rf_waddr,
    input  logic [data_w-1:0]     in_rf_wdata,
    input  logic                  in_csr_re,
    input  logic                  in_csr_we,
    input  logic [csr_num_w-1:0]  in_csr_num,
    input  logic [data_w-1:0]     in_csr_wmask,
    input  logic [data_w-1:0]     in_csr_wvalue,
    input  logic                  in_syscall,
    input  logic                  in_ertn,
    output logic                  in_allowin,
    // trace
    output logic [data_w-1:0]     debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [data_w-1:0]     debug_wb_rf_wdata,
    // redirect
    output logic                  flush,
    output logic [data_w-1:0]     flush_pc,
    // register file peek
    input  logic [reg_addr_w-1:0] dbg_raddr,
    output logic [data_w-1:0]     dbg_rdata
);

    logic                  ws_allowin;
    logic                  ms2ws_valid;
    logic [data_w-1:0]     ms_pc;
    logic                  ms_rf_we;
    logic [reg_addr_w-1:0] ms_rf_waddr;
    logic [data_w-1:0]     ms_rf_wdata;
    logic                  ms_csr_re;
    logic                  ms_csr_we;
    logic [csr_num_w-1:0]  ms_csr_num;
    logic [data_w-1:0]     ms_csr_wmask;
    logic [data_w-1:0]     ms_csr_wvalue;
    logic                  ms_syscall;
    logic                  ms_ertn;

    logic [csr_num_w-1:0]  csr_num;
    logic                  csr_we;
    logic [data_w-1:0]     csr_wmask;
    logic [data_w-1:0]     csr_wvalue;
    logic [data_w-1:0]     csr_rvalue;
    logic                  wb_ex;
    logic                  ertn_flush;
    logic [data_w-1:0]     wb_pc;
    logic [ecode_w-1:0]    wb_ecode;
    logic [esubcode_w-1:0] wb_esubcode;
    logic [data_w-1:0]     flush_target;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [data_w-1:0]     rf_wdata;

    assign flush    = wb_ex || ertn_flush;
    assign flush_pc = flush_target;

    mem_stage u_mem_stage (
        .clk           (clk),
        .resetn        (resetn),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_rf_we      (in_rf_we),
        .in_rf_waddr   (in_rf_waddr),
        .in_rf_wdata   (in_rf_wdata),
        .in_csr_re     (in_csr_re),
        .in_csr_we     (in_csr_we),
        .in_csr_num    (in_csr_num),
        .in_csr_wmask  (in_csr_wmask),
        .in_csr_wvalue (in_csr_wvalue),
        .in_syscall    (in_syscall),
        .in_ertn       (in_ertn),
        .in_allowin    (in_allowin),
        .ws_allowin    (ws_allowin),
        .flush         (flush),
        .ms2ws_valid   (ms2ws_valid),
        .ms_pc         (ms_pc),
        .ms_rf_we      (ms_rf_we),
        .ms_rf_waddr   (ms_rf_waddr),
        .ms_rf_wdata   (ms_rf_wdata),
        .ms_csr_re     (ms_csr_re),
        .ms_csr_we     (ms_csr_we),
        .ms_csr_num    (ms_csr_num),
        .ms_csr_wmask  (ms_csr_wmask),
        .ms_csr_wvalue (ms_csr_wvalue),
        .ms_syscall    (ms_syscall),
        .ms_ertn       (ms_ertn)
    );

    // csr_re stays inside wb_stage, the csr read is combinational
    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ms2ws_valid       (ms2ws_valid),
        .ms_pc             (ms_pc),
        .ms_rf_we          (ms_rf_we),
        .ms_rf_waddr       (ms_rf_waddr),
        .ms_rf_wdata       (ms_rf_wdata),
        .ms_csr_re         (ms_csr_re),
        .ms_csr_we         (ms_csr_we),
        .ms_csr_num        (ms_csr_num),
        .ms_csr_wmask      (ms_csr_wmask),
        .ms_csr_wvalue     (ms_csr_wvalue),
        .ms_syscall        (ms_syscall),
        .ms_ertn           (ms_ertn),
        .ws_allowin        (ws_allowin),
        .csr_re            (),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .wb_ex             (wb_ex),
        .ertn_flush        (ertn_flush),
        .wb_pc             (wb_pc),
        .wb_ecode          (wb_ecode),
        .wb_esubcode       (wb_esubcode),
        .csr_rvalue        (csr_rvalue),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .resetn       (resetn),
        .csr_num      (csr_num),
        .csr_we       (csr_we),
        .csr_wmask    (csr_wmask),
        .csr_wvalue   (csr_wvalue),
        .wb_ex        (wb_ex),
        .wb_pc        (wb_pc),
        .wb_ecode     (wb_ecode),
        .wb_esubcode  (wb_esubcode),
        .ertn_flush   (ertn_flush),
        .csr_rvalue   (csr_rvalue),
        .flush_target (flush_target)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (dbg_raddr),
        .rdata (dbg_rdata)
    );

endmodule

/* design/wb_stage.sv */
module wb_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // from memory stage
    input  logic                  ms2ws_valid,
    input  logic [data_w-1:0]     ms_pc,
    input  logic                  ms_rf_we,
    input  logic [reg_addr_w-1:0] ms_rf_waddr,
    input  logic [data_w-1:0]     ms_rf_wdata,
    input  logic                  ms_csr_re,
    input  logic                  ms_csr_we,
    input  logic [csr_num_w-1:0]  ms_csr_num,
    input  logic [data_w-1:0]     ms_csr_wmask,
    input  logic [data_w-1:0]     ms_csr_wvalue,
    input  logic                  ms_syscall,
    input  logic                  ms_ertn,
    output logic                  ws_allowin,
    // csr access
    output logic                  csr_re,
    output logic [csr_num_w-1:0]  csr_num,
    output logic                  csr_we,
    output logic [data_w-1:0]     csr_wmask,
    output logic [data_w-1:0]     csr_wvalue,
    output logic                  wb_ex,
    output logic                  ertn_flush,
    output logic [data_w-1:0]     wb_pc,
    output logic [ecode_w-1:0]    wb_ecode,
    output logic [esubcode_w-1:0] wb_esubcode,
    input  logic [data_w-1:0]     csr_rvalue,
    // register file write
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [data_w-1:0]     rf_wdata,
    // trace
    output logic [data_w-1:0]     debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [data_w-1:0]     debug_wb_rf_wdata
);

    logic                  ws_valid;
    logic                  ws_ready_go;
    logic [data_w-1:0]     ws_pc;
    logic                  ws_rf_we;
    logic [reg_addr_w-1:0] ws_rf_waddr;
    logic [data_w-1:0]     ws_rf_wdata;
    logic                  ws_csr_re;
    logic                  ws_csr_we;
    logic [csr_num_w-1:0]  ws_csr_num;
    logic [data_w-1:0]     ws_csr_wmask;
    logic [data_w-1:0]     ws_csr_wvalue;
    logic                  ws_syscall;
    logic                  ws_ertn;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (wb_ex || ertn_flush) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid && ws_allowin) begin
            ws_pc         <= ms_pc;
            ws_rf_we      <= ms_rf_we;
            ws_rf_waddr   <= ms_rf_waddr;
            ws_rf_wdata   <= ms_rf_wdata;
            ws_csr_re     <= ms_csr_re;
            ws_csr_we     <= ms_csr_we;
            ws_csr_num    <= ms_csr_num;
            ws_csr_wmask  <= ms_csr_wmask;
            ws_csr_wvalue <= ms_csr_wvalue;
            ws_syscall    <= ms_syscall;
            ws_ertn       <= ms_ertn;
        end
    end

    // csr side effects only for a live item
    assign csr_re      = ws_valid && ws_csr_re;
    assign csr_num     = ws_csr_num & {csr_num_w{ws_valid}};
    assign csr_we      = ws_valid && ws_csr_we;
    assign csr_wmask   = ws_csr_wmask & {data_w{ws_valid}};
    assign csr_wvalue  = ws_csr_wvalue & {data_w{ws_valid}};
    assign wb_ex       = ws_valid && ws_syscall;
    assign ertn_flush  = ws_valid && ws_ertn;
    assign wb_pc       = ws_pc & {data_w{ws_valid}};
    assign wb_ecode    = wb_ex ? ecode_sys : '0;
    assign wb_esubcode = '0;

    // syscall never writes its destination
    assign rf_we    = ws_valid && ws_rf_we && !ws_syscall;
    assign rf_waddr = ws_rf_waddr;
    assign rf_wdata = csr_re ? csr_rvalue : ws_rf_wdata;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* flist.f */
design/cpu_pkg.sv
design/mem_stage.sv
design/wb_stage.sv
design/csr_file.sv
design/reg_file.sv
design/wb_csr_top.sv
tests/tb_wb_csr.sv

/* tests/tb_wb_csr.sv */
module tb_wb_csr;

    localparam int num_instr = 33;
    // a serial instruction spans at most four cycles
    localparam int timeout_time = (num_instr * 4 + 50) * 20;

    localparam logic [13:0] n_crmd    = 14'h0;
    localparam logic [13:0] n_prmd    = 14'h1;
    localparam logic [13:0] n_estat   = 14'h5;
    localparam logic [13:0] n_era     = 14'h6;
    localparam logic [13:0] n_eentry  = 14'hc;
    localparam logic [13:0] n_save0   = 14'h30;
    localparam logic [13:0] n_save2   = 14'h32;
    localparam logic [13:0] n_unknown = 14'h40;

    // slots of the csr model
    localparam int s_crmd   = 0;
    localparam int s_prmd   = 1;
    localparam int s_estat  = 2;
    localparam int s_era    = 3;
    localparam int s_eentry = 4;
    localparam int s_save0  = 5;

    logic        clk;
    logic        resetn;
    logic        in_valid;
    logic [31:0] in_pc;
    logic        in_rf_we;
    logic [4:0]  in_rf_waddr;
    logic [31:0] in_rf_wdata;
    logic        in_csr_re;
    logic        in_csr_we;
    logic [13:0] in_csr_num;
    logic [31:0] in_csr_wmask;
    logic [31:0] in_csr_wvalue;
    logic        in_syscall;
    logic        in_ertn;
    logic        in_allowin;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        flush;
    logic [31:0] flush_pc;
    logic [4:0]  dbg_raddr;
    logic [31:0] dbg_rdata;

    integer      seed;
    logic [31:0] csr_m [0:8];
    logic [31:0] rf_m [0:31];
    logic [31:0] cur_pc;
    logic [31:0] issued_pc;

    wb_csr_top DUT (
        .clk               (clk),
        .resetn            (resetn),
        .in_valid          (in_valid),
        .in_pc             (in_pc),
        .in_rf_we          (in_rf_we),
        .in_rf_waddr       (in_rf_waddr),
        .in_rf_wdata       (in_rf_wdata),
        .in_csr_re         (in_csr_re),
        .in_csr_we         (in_csr_we),
        .in_csr_num        (in_csr_num),
        .in_csr_wmask      (in_csr_wmask),
        .in_csr_wvalue     (in_csr_wvalue),
        .in_syscall        (in_syscall),
        .in_ertn           (in_ertn),
        .in_allowin        (in_allowin),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .flush             (flush),
        .flush_pc          (flush_pc),
        .dbg_raddr         (dbg_raddr),
        .dbg_rdata         (dbg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(timeout_time);
        $display("Timeout: the tests did not finish within %0d time units", timeout_time);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic int slot_of(input logic [13:0] num);
        case (num)
            n_crmd:   return s_crmd;
            n_prmd:   return s_prmd;
            n_estat:  return s_estat;
            n_era:    return s_era;
            n_eentry: return s_eentry;
            14'h30:   return s_save0;
            14'h31:   return s_save0 + 1;
            14'h32:   return s_save0 + 2;
            14'h33:   return s_save0 + 3;
            default:  return -1;
        endcase
    endfunction

    // writable bits as the instruction set defines them
    function automatic logic [31:0] wmask_of(input logic [13:0] num);
        case (num)
            n_crmd, n_prmd: return 32'h0000_0007;
            n_estat:        return 32'h0000_0003;
            n_eentry:       return 32'hffff_ffc0;
            default:        return (slot_of(num) < 0) ? 32'h0 : 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] model_csr_read(input logic [13:0] num);
        int s;
        s = slot_of(num);
        if (s < 0) begin
            return 32'h0;
        end
        return csr_m[s];
    endfunction

    task automatic model_csr_write(input logic [13:0] num, input logic [31:0] mask,
                                   input logic [31:0] value);
        int          s;
        logic [31:0] m;
        s = slot_of(num);
        m = mask & wmask_of(num);
        if (s >= 0) begin
            csr_m[s] = (csr_m[s] & ~m) | (value & m);
        end
    endtask

    task automatic model_exception(input logic [31:0] pc);
        csr_m[s_prmd][2:0]    = csr_m[s_crmd][2:0];
        csr_m[s_crmd][2:0]    = 3'b000;
        csr_m[s_estat][21:16] = 6'hb;
        csr_m[s_estat][30:22] = 9'h0;
        csr_m[s_era]          = pc;
    endtask

    task automatic model_ertn();
        csr_m[s_crmd][2:0] = csr_m[s_prmd][2:0];
    endtask

    task automatic model_rf_write(input logic we, input logic [4:0] addr, input logic [31:0] data);
        if (we && addr != 5'd0) begin
            rf_m[addr] = data;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // from the sample point to just after the commit edge
    task automatic settle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        in_valid      = 1'b0;
        in_pc         = 32'h0;
        in_rf_we      = 1'b0;
        in_rf_waddr   = 5'd0;
        in_rf_wdata   = 32'h0;
        in_csr_re     = 1'b0;
        in_csr_we     = 1'b0;
        in_csr_num    = 14'h0;
        in_csr_wmask  = 32'h0;
        in_csr_wvalue = 32'h0;
        in_syscall    = 1'b0;
        in_ertn       = 1'b0;
        dbg_raddr     = 5'd0;
    endtask

    task automatic drive(input logic rf_we, input logic [4:0] waddr, input logic [31:0] wdata,
                         input logic csr_re, input logic csr_we, input logic [13:0] num,
                         input logic [31:0] wmask, input logic [31:0] wvalue,
                         input logic syscall, input logic ertn);
        while (!in_allowin) begin
            step();
        end
        in_valid      = 1'b1;
        in_pc         = cur_pc;
        in_rf_we      = rf_we;
        in_rf_waddr   = waddr;
        in_rf_wdata   = wdata;
        in_csr_re     = csr_re;
        in_csr_we     = csr_we;
        in_csr_num    = num;
        in_csr_wmask  = wmask;
        in_csr_wvalue = wvalue;
        in_syscall    = syscall;
        in_ertn       = ertn;
        issued_pc     = cur_pc;
        cur_pc        = cur_pc + 32'd4;
    endtask

    // issue one instruction and stop mid cycle while it sits in writeback
    task automatic exec(input logic rf_we, input logic [4:0] waddr, input logic [31:0] wdata,
                        input logic csr_re, input logic csr_we, input logic [13:0] num,
                        input logic [31:0] wmask, input logic [31:0] wvalue,
                        input logic syscall, input logic ertn);
        drive(rf_we, waddr, wdata, csr_re, csr_we, num, wmask, wvalue, syscall, ertn);
        step();
        in_valid = 1'b0;
        step();
        #8;
        check_eq("debug_wb_pc", debug_wb_pc, issued_pc);
    endtask

    task automatic csr_write(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        exec(1'b0, 5'd0, 32'h0, 1'b0, 1'b1, num, mask, value, 1'b0, 1'b0);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        check_eq("flush", flush, 1'b0);
        settle();
        model_csr_write(num, mask, value);
    endtask

    // csrrd when we is low, csrxchg when it is high
    task automatic csr_access(input logic [13:0] num, input logic we, input logic [31:0] mask,
                              input logic [31:0] value, input logic [4:0] waddr,
                              output logic [31:0] rvalue);
        logic [31:0] exp;
        exp = model_csr_read(num);
        exec(1'b1, waddr, $random(seed), 1'b1, we, num, mask, value, 1'b0, 1'b0);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'hf);
        check_eq("debug_wb_rf_wnum", debug_wb_rf_wnum, waddr);
        check_eq("debug_wb_rf_wdata", debug_wb_rf_wdata, exp);
        rvalue = debug_wb_rf_wdata;
        settle();
        model_rf_write(1'b1, waddr, exp);
        if (we) begin
            model_csr_write(num, mask, value);
        end
    endtask

    task automatic test_reset_state();
        check_eq("flush", flush, 1'b0);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        check_eq("in_allowin", in_allowin, 1'b1);
    endtask

    task automatic test_back_to_back();
        logic [31:0] exp_pc [0:5];
        logic [4:0]  exp_addr [0:5];
        logic [31:0] exp_data [0:5];
        for (int j = 0; j < 8; j++) begin
            if (j < 6) begin
                // last one targets r0
                exp_addr[j] = (j == 5) ? 5'd0 : 5'(j + 1);
                exp_data[j] = $random(seed);
                drive(1'b1, exp_addr[j], exp_data[j], 1'b0, 1'b0, 14'h0, 32'h0, 32'h0,
                      1'b0, 1'b0);
                exp_pc[j] = issued_pc;
            end else begin
                in_valid = 1'b0;
            end
            #8;
            if (j >= 2) begin
                check_eq("debug_wb_pc", debug_wb_pc, exp_pc[j-2]);
                check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'hf);
                check_eq("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_addr[j-2]);
                check_eq("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[j-2]);
                model_rf_write(1'b1, exp_addr[j-2], exp_data[j-2]);
            end else begin
                check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
            end
            step();
        end
        for (int r = 0; r < 6; r++) begin
            dbg_raddr = 5'(r);
            #8;
            check_eq("dbg_rdata", dbg_rdata, rf_m[r]);
            step();
        end
    endtask

    task automatic test_csr_write_read();
        logic [13:0] num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] rd;
        for (int k = 0; k < 5; k++) begin
            num   = (k < 4) ? 14'(n_save0 + k) : n_eentry;
            mask  = $random(seed);
            value = $random(seed);
            csr_write(num, mask, value);
            csr_access(num, 1'b0, 32'h0, 32'h0, 5'(10 + k), rd);
            if (num == n_eentry) begin
                check_eq("eentry low bits", rd & 32'h3f, 32'h0);
            end
        end
    endtask

    task automatic test_syscall_entry();
        logic [31:0] sys_pc;
        logic [31:0] rd;
        // plv 2 with interrupts on
        csr_write(n_crmd, 32'hffff_ffff, 32'h0000_0006);
        exec(1'b1, 5'd7, $random(seed), 1'b0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b1, 1'b0);
        sys_pc = issued_pc;
        check_eq("flush", flush, 1'b1);
        check_eq("flush_pc", flush_pc, csr_m[s_eentry]);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        settle();
        model_exception(sys_pc);
        check_eq("flush", flush, 1'b0);
        csr_access(n_estat, 1'b0, 32'h0, 32'h0, 5'd16, rd);
        check_eq("estat ecode", rd[21:16], 6'hb);
        csr_access(n_era, 1'b0, 32'h0, 32'h0, 5'd17, rd);
        check_eq("era", rd, sys_pc);
        csr_access(n_prmd, 1'b0, 32'h0, 32'h0, 5'd18, rd);
        check_eq("prmd pplv and pie", rd[2:0], 3'b110);
        csr_access(n_crmd, 1'b0, 32'h0, 32'h0, 5'd19, rd);
        check_eq("crmd plv and ie", rd[2:0], 3'b000);
    endtask

    task automatic test_flush_discard();
        logic [31:0] sys_pc;
        logic [31:0] young_data;
        drive(1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b1, 1'b0);
        sys_pc = issued_pc;
        step();
        // younger write to r3 right behind the syscall
        young_data = $random(seed);
        drive(1'b1, 5'd3, young_data, 1'b0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        step();
        in_valid = 1'b0;
        #8;
        check_eq("flush", flush, 1'b1);
        check_eq("flush_pc", flush_pc, csr_m[s_eentry]);
        check_eq("debug_wb_pc", debug_wb_pc, sys_pc);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        step();
        model_exception(sys_pc);
        repeat (3) begin
            #8;
            check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
            check_eq("flush", flush, 1'b0);
            step();
        end
        dbg_raddr = 5'd3;
        #8;
        check_eq("dbg_rdata", dbg_rdata, rf_m[3]);
        step();
    endtask

    task automatic test_ertn_return();
        logic [31:0] sys_pc;
        logic [31:0] rd;
        // plv 3 with interrupts off
        csr_write(n_crmd, 32'h0000_0007, 32'h0000_0003);
        exec(1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b1, 1'b0);
        sys_pc = issued_pc;
        check_eq("flush", flush, 1'b1);
        check_eq("flush_pc", flush_pc, csr_m[s_eentry]);
        settle();
        model_exception(sys_pc);
        exec(1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 1'b1);
        check_eq("flush", flush, 1'b1);
        check_eq("flush_pc", flush_pc, sys_pc);
        check_eq("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        settle();
        model_ertn();
        csr_access(n_crmd, 1'b0, 32'h0, 32'h0, 5'd21, rd);
        check_eq("crmd plv and ie", rd[2:0], 3'b011);
        csr_access(n_prmd, 1'b0, 32'h0, 32'h0, 5'd22, rd);
        check_eq("prmd pplv and pie", rd[2:0], 3'b011);
    endtask

    task automatic test_exchange();
        logic [31:0] old;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] rd;
        for (int k = 0; k < 2; k++) begin
            old   = csr_m[s_save0 + 2];
            mask  = $random(seed);
            value = $random(seed);
            csr_access(n_save2, 1'b1, mask, value, 5'd25, rd);
            check_eq("csrxchg old value", rd, old);
        end
        // numbers outside the set ignore writes
        csr_write(n_unknown, 32'hffff_ffff, $random(seed));
        csr_access(n_unknown, 1'b0, 32'h0, 32'h0, 5'd26, rd);
        check_eq("unknown csr", rd, 32'h0);
    endtask

    initial begin
        seed   = 34333;
        cur_pc = 32'h1c00_0000;
        clear_inputs();
        resetn = 1'b0;
        for (int i = 0; i < 9; i++) begin
            csr_m[i] = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            rf_m[i] = 32'h0;
        end
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;

        test_reset_state();
        test_back_to_back();
        test_csr_write_read();
        test_syscall_entry();
        test_flush_discard();
        test_ertn_return();
        test_exchange();

        $display("All tests passed");
        $finish;
    end

endmodule
